/* bench/mult_sva.sv */
////////////////////////////////////////////////////////////////////////////
// checker bound into mult_top
// compares every result with reference arithmetic and watches req/ack
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                req_i,
  input mult_pkg::mult_req_t req_data_i,
  input logic                ack_o,
  input mult_pkg::mult_rsp_t rsp_o
);
  import mult_pkg::*;

  // failed checks so far, read by the testbench
  int unsigned err_cnt = 0;

  ////////////////////////////////////////////////////////////////////////////
  // reference arithmetic
  ////////////////////////////////////////////////////////////////////////////

  // selected halves times each other plus c and rounding, then shifted
  function automatic logic [31:0] short_ref(mult_req_t r);
    logic [15:0]        ha;
    logic [15:0]        hb;
    logic [31:0]        ea;
    logic [31:0]        eb;
    logic [31:0]        rnd;
    logic [31:0]        sum;
    logic signed [31:0] sum_s;
    ha  = r.short_subword ? r.op_a[31:16] : r.op_a[15:0];
    hb  = r.short_subword ? r.op_b[31:16] : r.op_b[15:0];
    ea  = {{16{r.short_signed[0] & ha[15]}}, ha};
    eb  = {{16{r.short_signed[1] & hb[15]}}, hb};
    rnd = 32'd0;
    // half an lsb of the shifted result
    if (r.op == MUL_IR && r.imm != 5'd0) begin
      rnd = 32'd1 << (r.imm - 5'd1);
    end
    sum   = ea * eb + r.op_c + rnd;
    sum_s = sum;
    if (r.short_signed[0]) begin
      return sum_s >>> r.imm;
    end else begin
      return sum >> r.imm;
    end
  endfunction

  // upper word of the full 64-bit product
  function automatic logic [31:0] high_ref(mult_req_t r);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    ea   = {{32{r.short_signed[0] & r.op_a[31]}}, r.op_a};
    eb   = {{32{r.short_signed[1] & r.op_b[31]}}, r.op_b};
    prod = ea * eb;
    return prod[63:32];
  endfunction

  // c plus the lane products, byte or halfword lanes
  function automatic logic [31:0] dot_ref(mult_req_t r, bit bytes);
    logic [31:0] acc;
    logic [31:0] ea;
    logic [31:0] eb;
    acc = r.op_c;
    if (bytes) begin
      for (int i = 0; i < 4; i++) begin
        ea  = {{24{r.dot_signed[1] & r.op_a[8*i+7]}}, r.op_a[8*i +: 8]};
        eb  = {{24{r.dot_signed[0] & r.op_b[8*i+7]}}, r.op_b[8*i +: 8]};
        acc = acc + ea * eb;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        ea  = {{16{r.dot_signed[1] & r.op_a[16*i+15]}}, r.op_a[16*i +: 16]};
        eb  = {{16{r.dot_signed[0] & r.op_b[16*i+15]}}, r.op_b[16*i +: 16]};
        acc = acc + ea * eb;
      end
    end
    return acc;
  endfunction

  function automatic logic [31:0] expected_result(mult_req_t r);
    case (r.op)
      MUL_MAC32: return r.op_c + r.op_a * r.op_b;
      MUL_MSU32: return r.op_c - r.op_a * r.op_b;
      MUL_I:     return short_ref(r);
      MUL_IR:    return short_ref(r);
      MUL_H:     return high_ref(r);
      MUL_DOT8:  return dot_ref(r, 1'b1);
      MUL_DOT16: return dot_ref(r, 1'b0);
      default:   return 32'd0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // results
  ////////////////////////////////////////////////////////////////////////////

  check_result: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_o) |-> rsp_o.result == expected_result(req_data_i))
    else begin
      err_cnt++;
      $error("ERR %0t: %s gave %h, expected %h", $time, req_data_i.op.name(),
             rsp_o.result, expected_result(req_data_i));
    end

  // only the stepped high multiply marks its response
  check_multicycle: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_o) |-> rsp_o.multicycle == (req_data_i.op == MUL_H))
    else begin
      err_cnt++;
      $error("ERR %0t: multicycle flag is %b for %s", $time, rsp_o.multicycle,
             req_data_i.op.name());
    end

  ////////////////////////////////////////////////////////////////////////////
  // four-phase handshake
  ////////////////////////////////////////////////////////////////////////////

  check_reset: assert property (@(posedge clk) !rst_n |=> !ack_o)
    else begin
      err_cnt++;
      $error("ack was high during or right after reset at %0t", $time);
    end

  check_req_rule: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req_i) |-> !ack_o)
    else begin
      err_cnt++;
      $error("request was raised while ack was still high at %0t", $time);
    end

  check_single_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req_i) && req_data_i.op != MUL_H |-> !ack_o ##1 ack_o)
    else begin
      err_cnt++;
      $error("ack did not rise one cycle after a single-cycle request at %0t", $time);
    end

  // three partial steps and the finishing step before ack
  check_high_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req_i) && req_data_i.op == MUL_H
      |-> !ack_o ##1 !ack_o ##1 !ack_o ##1 !ack_o ##1 !ack_o ##1 ack_o)
    else begin
      err_cnt++;
      $error("ack did not rise four cycles after a high multiply at %0t", $time);
    end

  check_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ack_o && req_i |=> ack_o && $stable(rsp_o))
    else begin
      err_cnt++;
      $error("ack or the response changed while the request was held at %0t", $time);
    end

  check_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(req_i) |-> ack_o ##1 !ack_o)
    else begin
      err_cnt++;
      $error("ack did not fall one cycle after the request dropped at %0t", $time);
    end

endmodule

bind mult_top mult_sva u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .req_i      (req_i),
  .req_data_i (req_data_i),
  .ack_o      (ack_o),
  .rsp_o      (rsp_o)
);

/* bench/mult_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench of the multiply unit
// random and directed operations through req/ack, checked by mult_sva
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_tb;
  import mult_pkg::*;

  localparam int unsigned SEED     = 32'h5608_6536;
  // transactions per operator or signedness code
  localparam int          N_MAC    = 8;
  localparam int          N_SHORT  = 12;
  localparam int          N_HIGH   = 8;
  localparam int          N_DIR    = 5;
  localparam int          N_DOT    = 8;
  localparam int          N_HS     = 4;
  localparam int          N_B2B    = 3;
  localparam int          N_TXN    = 2 * N_MAC + 2 * N_SHORT + 3 * N_HIGH + N_DIR
                                     + 2 * N_DOT + N_HS + 2 * N_B2B;
  // ten cycles of 10 ns per transaction, margin for reset and held requests
  localparam int          WATCHDOG = N_TXN * 10 * 10 + 2000;
  localparam int          ACK_WAIT = 20;

  logic        clk;
  logic        rst_n;
  logic        req;
  mult_req_t   req_data;
  logic        ack;
  mult_rsp_t   rsp;

  int unsigned timeouts;
  int unsigned mark;
  int unsigned tests_passed;
  int unsigned tests_failed;

  mult_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req),
    .req_data_i (req_data),
    .ack_o      (ack),
    .rsp_o      (rsp)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned total_errors();
    return UUT.u_sva.err_cnt + timeouts;
  endfunction

  function automatic mult_req_t rand_req(input mult_op_e op);
    mult_req_t r;
    r.op            = op;
    r.short_signed  = 2'($urandom);
    r.short_subword = 1'($urandom);
    r.dot_signed    = 2'($urandom);
    r.imm           = 5'($urandom);
    r.op_a          = $urandom;
    r.op_b          = $urandom;
    r.op_c          = $urandom;
    // both operands share one signedness here
    if (op == MUL_H) begin
      r.short_signed = {2{r.short_signed[0]}};
    end
    return r;
  endfunction

  // one four-phase transaction, req held for hold cycles after ack
  task automatic transact(input mult_req_t r, input int hold);
    int waited;
    @(negedge clk);
    req_data = r;
    req      = 1'b1;
    waited   = 0;
    while (!ack && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (!ack) begin
      $display("timeout: no ack for a %s request at %0t", r.op.name(), $time);
      timeouts++;
    end
    repeat (hold) @(negedge clk);
    req    = 1'b0;
    waited = 0;
    while (ack && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (ack) begin
      $display("timeout: ack stayed high after the request dropped at %0t", $time);
      timeouts++;
    end
  endtask

  task automatic run_high(input logic [31:0] a, input logic [31:0] b, input logic [1:0] sgn);
    mult_req_t r;
    r              = rand_req(MUL_H);
    r.op_a         = a;
    r.op_b         = b;
    r.short_signed = sgn;
    transact(r, 0);
  endtask

  task automatic finish_test(input string name);
    int unsigned errs;
    errs = total_errors() - mark;
    mark = total_errors();
    if (errs == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d failed checks", name, errs);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    mult_req_t r;
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = 1'b0;
    req_data     = '0;
    timeouts     = 0;
    mark         = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(SEED));

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < N_MAC; i++) begin
      transact(rand_req(MUL_MAC32), 0);
      transact(rand_req(MUL_MSU32), 0);
    end
    finish_test("mac32/msu32");

    for (int i = 0; i < N_SHORT; i++) begin
      transact(rand_req(MUL_I), 0);
      transact(rand_req(MUL_IR), 0);
    end
    finish_test("short mac");

    // all three signedness codes at random, then corner operands
    for (int i = 0; i < N_HIGH; i++) begin
      run_high($urandom, $urandom, 2'b00);
      run_high($urandom, $urandom, 2'b11);
      run_high($urandom, $urandom, 2'b01);
    end
    run_high(32'hFFFF_FFF9, 32'h1234_5678, 2'b01);
    run_high(32'h8000_0000, 32'hFFFF_FFFF, 2'b01);
    run_high(32'h1234_5678, 32'h9ABC_DEF0, 2'b01);
    // middle partial sum overflows 32 bits while still positive
    run_high(32'h7FFF_FFFF, 32'hFFFF_FFFF, 2'b01);
    run_high(32'h8000_0000, 32'h8000_0000, 2'b11);
    finish_test("high multiply");

    for (int i = 0; i < N_DOT; i++) begin
      transact(rand_req(MUL_DOT8), 0);
      transact(rand_req(MUL_DOT16), 0);
    end
    finish_test("dot product");

    // back-pressure, ack and rsp must stay put while req is held
    transact(rand_req(MUL_I), 3);
    transact(rand_req(MUL_H), 5);
    transact(rand_req(MUL_MAC32), 1);
    transact(rand_req(MUL_DOT8), 0);
    finish_test("handshake");

    // carry from the high multiply must not leak into the next result
    for (int i = 0; i < N_B2B; i++) begin
      transact(rand_req(MUL_H), 0);
      r = rand_req(MUL_I);
      transact(r, 0);
    end
    finish_test("back to back");

    $display("tests: %0d passed, %0d failed, %0d failed checks",
             tests_passed, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* compile.f */
+incdir+hw
hw/mult_pkg.sv
hw/mult_seq_fsm.sv
hw/mult_step_counter.sv
hw/mult_short_mac.sv
hw/mult_dot_lanes.sv
hw/mult_result_stage.sv
hw/mult_top.sv
bench/mult_sva.sv
bench/mult_tb.sv

/* hw/mult_dot_lanes.sv */
////////////////////////////////////////////////////////////////////////////
// lane-parallel dot product with accumulate
// lane_t sets the lane payload, byte lanes or halfword lanes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_dot_lanes #(
  parameter type lane_t = logic [7:0]
) (
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  input  logic [31:0] c_i,
  input  logic [1:0]  signed_i,
  output logic [31:0] result_o
);

  localparam int unsigned LW = $bits(lane_t);
  localparam int unsigned NL = 32 / LW;
  // product of two sign-extended lanes
  localparam int unsigned PW = 2 * LW + 2;

  lane_t [NL-1:0]       a_lanes;
  lane_t [NL-1:0]       b_lanes;
  logic  [NL-1:0][31:0] lane_prod;
  logic  [31:0]         sum;

  assign a_lanes = a_i;
  assign b_lanes = b_i;

  for (genvar i = 0; i < NL; i++) begin : g_lane
    logic signed [LW:0]   a_ext;
    logic signed [LW:0]   b_ext;
    logic signed [PW-1:0] prod;

    // signed_i[1] for a, signed_i[0] for b
    assign a_ext = {signed_i[1] & a_lanes[i][LW-1], a_lanes[i]};
    assign b_ext = {signed_i[0] & b_lanes[i][LW-1], b_lanes[i]};
    assign prod  = PW'(a_ext) * PW'(b_ext);

    // extended for byte lanes, truncated for halfword lanes
    assign lane_prod[i] = 32'(prod);
  end

  // lane products summed into the accumulator, modulo 2^32
  always_comb begin
    sum = c_i;
    for (int i = 0; i < NL; i++) begin
      sum = sum + lane_prod[i];
    end
  end

  assign result_o = sum;

endmodule

/* hw/mult_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types of the multiply-accumulate unit
// operator encoding, request and response payloads, high-multiply controls
////////////////////////////////////////////////////////////////////////////

`include "mult_settings.svh"

package mult_pkg;

  // operator encoding, matches the execute stage of the core
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'b000,
    MUL_MSU32 = 3'b001,
    MUL_I     = 3'b010,
    MUL_IR    = 3'b011,
    MUL_DOT8  = 3'b100,
    MUL_DOT16 = 3'b101,
    MUL_H     = 3'b110
  } mult_op_e;

  // one operation as handed over by the requester
  typedef struct packed {
    mult_op_e              op;
    // bit 0 for operand a, bit 1 for operand b
    logic [1:0]            short_signed;
    // selects the upper halves of a and b
    logic                  short_subword;
    // bit 1 for operand a, bit 0 for operand b
    logic [1:0]            dot_signed;
    logic [4:0]            imm;
    logic [`MULT_DW-1:0]   op_a;
    logic [`MULT_DW-1:0]   op_b;
    logic [`MULT_DW-1:0]   op_c;
  } mult_req_t;

  // response held while ack is high
  typedef struct packed {
    logic [`MULT_DW-1:0]   result;
    // set when the result came out of the stepped high multiply
    logic                  multicycle;
  } mult_rsp_t;

  // per-step controls for the short MAC during a high multiply
  typedef struct packed {
    logic                  active;
    logic [1:0]            subword;
    logic [1:0]            signed_sel;
    logic                  shift_arith;
    logic [4:0]            imm;
    logic                  save;
  } mulh_ctrl_t;

endpackage

/* hw/mult_result_stage.sv */
////////////////////////////////////////////////////////////////////////////
// 32-bit MAC/MSU, result select by operator and the response register
// the response is captured once per operation and held for the handshake
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_result_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  mult_pkg::mult_req_t req_i,
  input  logic [31:0]         short_i,
  input  logic [31:0]         dot8_i,
  input  logic [31:0]         dot16_i,
  input  logic                capture_i,
  input  logic                multicycle_i,
  output mult_pkg::mult_rsp_t rsp_o
);
  import mult_pkg::*;

  logic        is_msu;
  logic [31:0] int_a;
  logic [31:0] int_b;
  logic [31:0] int_result;
  logic [31:0] result;
  mult_rsp_t   rsp_q;

  // msu: (~a) * b + b = -(a * b), so one multiplier serves both
  assign is_msu = (req_i.op == MUL_MSU32);
  assign int_a  = req_i.op_a ^ {32{is_msu}};
  assign int_b  = req_i.op_b & {32{is_msu}};

  assign int_result = req_i.op_c + int_b + int_a * req_i.op_b;

  always_comb begin
    case (req_i.op)
      MUL_MAC32, MUL_MSU32:  result = int_result;
      MUL_I, MUL_IR, MUL_H:  result = short_i;
      MUL_DOT8:              result = dot8_i;
      MUL_DOT16:             result = dot16_i;
      default:               result = '0;
    endcase
  end

  // held until the next capture, so it stays stable under back-pressure
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_q <= '0;
    end else if (capture_i) begin
      rsp_q.result     <= result;
      rsp_q.multicycle <= multicycle_i;
    end
  end

  assign rsp_o = rsp_q;

endmodule

/* hw/mult_seq_fsm.sv */
////////////////////////////////////////////////////////////////////////////
// sequencer of the multiply unit
// runs the four-phase req/ack handshake and steps the high multiply
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mult_settings.svh"

module mult_seq_fsm (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  mult_pkg::mult_op_e   op_i,
  input  logic [1:0]           short_signed_i,
  input  logic [1:0]           step_i,
  input  logic                 last_i,
  output logic                 start_o,
  output mult_pkg::mulh_ctrl_t mulh_ctrl_o,
  output logic                 capture_o,
  output logic                 multicycle_o,
  output logic                 ack_o
);
  import mult_pkg::*;

  localparam logic [4:0] HSHIFT = 5'(`MULT_MULH_SHIFT);

  typedef enum logic [1:0] {IDLE, STEP, FINISH, ACK} state_e;

  state_e state_q;
  state_e state_d;

  always_comb begin
    state_d      = state_q;
    start_o      = 1'b0;
    capture_o    = 1'b0;
    multicycle_o = 1'b0;
    mulh_ctrl_o  = '0;

    case (state_q)
      IDLE: begin
        if (req_i) begin
          // high multiply loads the step counter, the rest finish right away
          if (op_i == MUL_H) begin
            start_o = 1'b1;
            state_d = STEP;
          end else begin
            capture_o = 1'b1;
            state_d   = ACK;
          end
        end
      end

      STEP: begin
        mulh_ctrl_o.active = 1'b1;
        mulh_ctrl_o.save   = 1'b1;
        case (step_i)
          // a high x b low, a carries its own sign
          2'd1: begin
            mulh_ctrl_o.subword    = 2'b01;
            mulh_ctrl_o.signed_sel = {1'b0, short_signed_i[0]};
          end
          // a low x b high, shifted down, sign follows operand a
          2'd2: begin
            mulh_ctrl_o.subword     = 2'b10;
            mulh_ctrl_o.signed_sel  = {short_signed_i[1], 1'b0};
            mulh_ctrl_o.shift_arith = short_signed_i[0];
            mulh_ctrl_o.imm         = HSHIFT;
          end
          // low x low, both unsigned, keep only the upper half
          default: begin
            mulh_ctrl_o.imm = HSHIFT;
          end
        endcase
        if (last_i) begin
          state_d = FINISH;
        end
      end

      FINISH: begin
        // high x high plus the saved partial and carry
        mulh_ctrl_o.active     = 1'b1;
        mulh_ctrl_o.subword    = 2'b11;
        mulh_ctrl_o.signed_sel = short_signed_i;
        capture_o              = 1'b1;
        multicycle_o           = 1'b1;
        state_d                = ACK;
      end

      ACK: begin
        // hold until the requester lets go
        if (!req_i) begin
          state_d = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign ack_o = (state_q == ACK);

endmodule

/* hw/mult_settings.svh */
////////////////////////////////////////////////////////////////////////////
// width and step constants for the subword multiply-accumulate unit
// include in any file that sizes datapaths or times the high multiply
////////////////////////////////////////////////////////////////////////////

`ifndef MULT_SETTINGS_SVH
`define MULT_SETTINGS_SVH

// operand and result width
`define MULT_DW 32

// subword width used by the short MAC and the halfword dot product
`define MULT_SW 16

// partial steps of a high multiply, before the finishing step
`define MULT_MULH_STEPS 3

// shift applied in the first and third partial steps
`define MULT_MULH_SHIFT 16

`endif

/* hw/mult_short_mac.sv */
////////////////////////////////////////////////////////////////////////////
// 16x16 MAC with subword select, rounding and arithmetic right shift
// also runs the partial steps of the high multiply with a saved carry
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mult_settings.svh"

module mult_short_mac (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mult_pkg::mult_req_t  req_i,
  input  mult_pkg::mulh_ctrl_t ctrl_i,
  input  logic                 clear_i,
  output logic [31:0]          result_o
);
  import mult_pkg::*;

  localparam int unsigned SW = `MULT_SW;
  localparam int unsigned DW = `MULT_DW;
  // accumulator plus carry plus one sign bit for the shifter
  localparam int unsigned MW = DW + 2;

  logic [1:0]    subword;
  logic [1:0]    sgn;
  logic          shift_arith;
  logic          shift_ext;
  logic [4:0]    imm;
  logic [SW-1:0] half_a;
  logic [SW-1:0] half_b;
  logic [SW:0]   op_a;
  logic [SW:0]   op_b;
  logic [DW:0]   acc;
  logic [DW-1:0] round_one;
  logic [DW-1:0] round_val;
  logic [MW-1:0] prod;
  logic [MW-1:0] mac;
  logic          mac_top;
  logic          mac_msb;
  logic [MW-1:0] shifted;
  logic          carry_q;
  logic [DW-1:0] partial_q;

  // stepped controls take over while a high multiply runs
  assign subword     = ctrl_i.active ? ctrl_i.subword     : {2{req_i.short_subword}};
  assign sgn         = ctrl_i.active ? ctrl_i.signed_sel  : req_i.short_signed;
  assign shift_arith = ctrl_i.active ? ctrl_i.shift_arith : req_i.short_signed[0];
  assign shift_ext   = ctrl_i.active | req_i.short_signed[0];
  assign imm         = ctrl_i.active ? ctrl_i.imm         : req_i.imm;

  // subword selection
  assign half_a = subword[0] ? req_i.op_a[SW +: SW] : req_i.op_a[0 +: SW];
  assign half_b = subword[1] ? req_i.op_b[SW +: SW] : req_i.op_b[0 +: SW];

  // 17-bit operands, bit 16 is the sign when the half is signed
  assign op_a = {sgn[0] & half_a[SW-1], half_a};
  assign op_b = {sgn[1] & half_b[SW-1], half_b};

  // high multiply accumulates the previous partial with its carry
  assign acc = ctrl_i.active ? {carry_q, partial_q} : {1'b0, req_i.op_c};

  // half an lsb at the shift position
  assign round_one = DW'(1) << req_i.imm;
  assign round_val = (req_i.op == MUL_IR) ? (round_one >> 1) : '0;

  // operands sign-extended to full width, low bits of the product are exact
  assign prod = {{(MW-SW-1){op_a[SW]}}, op_a} * {{(MW-SW-1){op_b[SW]}}, op_b};
  assign mac  = {{(MW-DW-1){acc[DW]}}, acc} + prod + {{(MW-DW){1'b0}}, round_val};

  // sign source: bits 33 and 32 carry it during the high multiply
  assign mac_top = ctrl_i.active ? mac[DW+1] : mac[DW-1];
  assign mac_msb = ctrl_i.active ? mac[DW]   : mac[DW-1];

  assign shifted = $signed({shift_arith & mac_top, shift_ext & mac_msb, mac[DW-1:0]}) >>> imm;

  assign result_o = shifted[DW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // partial result and carry between high-multiply steps
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry_q   <= 1'b0;
      partial_q <= '0;
    end else if (clear_i) begin
      // next operation starts from zero
      carry_q   <= 1'b0;
      partial_q <= '0;
    end else if (ctrl_i.save) begin
      carry_q   <= shifted[DW];
      partial_q <= shifted[DW-1:0];
    end
  end

endmodule

/* hw/mult_step_counter.sv */
////////////////////////////////////////////////////////////////////////////
// step counter of the high multiply
// loaded by the sequencer, reports step index and the final partial step
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mult_settings.svh"

module mult_step_counter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start_i,
  output logic [1:0] step_o,
  output logic       last_o,
  output logic       busy_o
);

  localparam logic [1:0] STEPS = 2'(`MULT_MULH_STEPS);

  // remaining partial steps
  logic [1:0] cnt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= 2'd0;
    end else if (start_i) begin
      cnt_q <= STEPS;
    end else if (busy_o) begin
      cnt_q <= cnt_q - 2'd1;
    end
  end

  assign busy_o = (cnt_q != 2'd0);
  // index counts up from 0 while the remainder counts down
  assign step_o = STEPS - cnt_q;
  assign last_o = (cnt_q == 2'd1);

endmodule

/* hw/mult_top.sv */
////////////////////////////////////////////////////////////////////////////
// subword multiply-accumulate unit, top level
// one operation per four-phase req/ack handshake, result held in rsp_o
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mult_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,
  input  mult_pkg::mult_req_t req_data_i,
  output logic                ack_o,
  output mult_pkg::mult_rsp_t rsp_o
);
  import mult_pkg::*;

  logic        start;
  logic [1:0]  step;
  logic        last;
  mulh_ctrl_t  mulh_ctrl;
  logic        capture;
  logic        multicycle;
  logic [31:0] short_res;
  logic [31:0] dot8_res;
  logic [31:0] dot16_res;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  mult_seq_fsm u_seq (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .op_i           (req_data_i.op),
    .short_signed_i (req_data_i.short_signed),
    .step_i         (step),
    .last_i         (last),
    .start_o        (start),
    .mulh_ctrl_o    (mulh_ctrl),
    .capture_o      (capture),
    .multicycle_o   (multicycle),
    .ack_o          (ack_o)
  );

  // busy only matters inside the counter, the sequencer tracks last
  mult_step_counter u_cnt (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start),
    .step_o  (step),
    .last_o  (last),
    .busy_o  ()
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  mult_short_mac u_short (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (req_data_i),
    .ctrl_i   (mulh_ctrl),
    .clear_i  (capture),
    .result_o (short_res)
  );

  // byte lanes
  mult_dot_lanes #(
    .lane_t (logic [7:0])
  ) u_dot8 (
    .a_i      (req_data_i.op_a),
    .b_i      (req_data_i.op_b),
    .c_i      (req_data_i.op_c),
    .signed_i (req_data_i.dot_signed),
    .result_o (dot8_res)
  );

  // halfword lanes
  mult_dot_lanes #(
    .lane_t (logic [15:0])
  ) u_dot16 (
    .a_i      (req_data_i.op_a),
    .b_i      (req_data_i.op_b),
    .c_i      (req_data_i.op_c),
    .signed_i (req_data_i.dot_signed),
    .result_o (dot16_res)
  );

  mult_result_stage u_res (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_data_i),
    .short_i      (short_res),
    .dot8_i       (dot8_res),
    .dot16_i      (dot16_res),
    .capture_i    (capture),
    .multicycle_i (multicycle),
    .rsp_o        (rsp_o)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the multiply unit testbench with Verilator and runs it
# the verdict comes from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mult_tb -f compile.f \
  -Mdir obj_dir -o Vmult_tb > build.log 2>&1 ||
  { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vmult_tb +verilator+error+limit+1000 > sim.log 2>&1 ||
  echo "simulator returned a failing status"
cat sim.log

grep -qx "TESTS PASSED" sim.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
